//--- list.f
src/cache_cfg_pkg.sv
src/cache_bus_pkg.sv
src/dp_ram.sv
src/cache_array.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/cache_sva.sv
testbench/cache_checker.sv
testbench/tb_cache.sv

//--- testbench/tb_cache.sv
// Data cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam int          RESET_CYCLES    = 16;
    localparam int          CYCLES_PER_STEP = 80;
    localparam int          LINE_TOTAL      = 1 << (ADDR_WIDTH - OFFSET_WIDTH);
    localparam logic [31:0] SEED            = 32'h77fa_bee1;

    // one table row where hit and wb give the expected memory traffic of the access
    typedef struct packed {
        logic   write;
        addr_t  addr;
        word_t  wdata;
        logic   hit;
        logic   wb;
    } stim_t;

    logic       clk = 1'b0;
    logic       n_rst = 1'b0;
    cpu_req_t   req = '0;
    logic       req_valid = 1'b0;
    logic       req_ready;
    cpu_rsp_t   rsp;
    logic       rsp_valid;
    logic       rsp_ready = 1'b0;
    mem_req_t   mem_req;
    logic       mem_req_valid;
    logic       mem_req_ready = 1'b0;
    mem_rsp_t   mem_rsp = '0;
    logic       mem_rsp_valid = 1'b0;
    logic       mem_rsp_ready;
    logic       exp_hit = 1'b0;
    logic       exp_wb = 1'b0;

    line_t      mem_lines [LINE_TOTAL];
    line_addr_t rd_addr = '0;
    int         rd_delay = 0;
    logic       rd_pending = 1'b0;

    stim_t      stim_q [$];
    int         rsp_count = 0;
    int         cycles = 0;
    int         cycle_limit;
    int         chk_errors;
    int         sva_errors;

    always #50 clk = ~clk;

    cache_top DUT (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_req           (req),
        .i_req_valid     (req_valid),
        .o_req_ready     (req_ready),
        .o_rsp           (rsp),
        .o_rsp_valid     (rsp_valid),
        .i_rsp_ready     (rsp_ready),
        .o_mem_req       (mem_req),
        .o_mem_req_valid (mem_req_valid),
        .i_mem_req_ready (mem_req_ready),
        .i_mem_rsp       (mem_rsp),
        .i_mem_rsp_valid (mem_rsp_valid),
        .o_mem_rsp_ready (mem_rsp_ready)
    );

    cache_checker u_checker (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_req           (req),
        .i_req_valid     (req_valid),
        .i_req_ready     (req_ready),
        .i_exp_hit       (exp_hit),
        .i_exp_wb        (exp_wb),
        .i_rsp           (rsp),
        .i_rsp_valid     (rsp_valid),
        .i_rsp_ready     (rsp_ready),
        .i_mem_req       (mem_req),
        .i_mem_req_valid (mem_req_valid),
        .i_mem_req_ready (mem_req_ready),
        .i_mem_rsp_valid (mem_rsp_valid),
        .i_mem_rsp_ready (mem_rsp_ready),
        .o_errors        (chk_errors)
    );

    function automatic word_t initial_word(input int unsigned waddr);
        return (word_t'(waddr) * 32'h0001_0001) ^ 32'hA5A5_0000;
    endfunction

    task automatic add_step(input logic write, input addr_t addr, input word_t wdata,
                            input logic hit, input logic wb);
        stim_t s;
        s.write = write;
        s.addr  = addr;
        s.wdata = wdata;
        s.hit   = hit;
        s.wb    = wb;
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        add_step(1'b0, 16'h0100, 32'h0, 1'b0, 1'b0);
        add_step(1'b0, 16'h0104, 32'h0, 1'b1, 1'b0);
        add_step(1'b1, 16'h0108, 32'h1111_0001, 1'b1, 1'b0);
        add_step(1'b0, 16'h0108, 32'h0, 1'b1, 1'b0);
        // write miss refills first, then merges the word
        add_step(1'b1, 16'h0214, 32'h2222_0002, 1'b0, 1'b0);
        add_step(1'b0, 16'h0214, 32'h0, 1'b1, 1'b0);
        add_step(1'b0, 16'h0210, 32'h0, 1'b1, 1'b0);
        add_step(1'b0, 16'h0300, 32'h0, 1'b0, 1'b1);
        add_step(1'b0, 16'h0108, 32'h0, 1'b0, 1'b0);
        add_step(1'b0, 16'h0320, 32'h0, 1'b0, 1'b0);
        add_step(1'b0, 16'h0420, 32'h0, 1'b0, 1'b0);
        add_step(1'b1, 16'h042C, 32'h3333_0003, 1'b1, 1'b0);
        add_step(1'b1, 16'h0420, 32'h4444_0004, 1'b1, 1'b0);
        add_step(1'b0, 16'h0520, 32'h0, 1'b0, 1'b1);
        add_step(1'b0, 16'h042C, 32'h0, 1'b0, 1'b0);
        add_step(1'b0, 16'h0420, 32'h0, 1'b1, 1'b0);
        add_step(1'b1, 16'hFFF0, 32'h5555_0005, 1'b0, 1'b0);
        add_step(1'b1, 16'hFFFC, 32'h6666_0006, 1'b1, 1'b0);
        add_step(1'b0, 16'h0FF4, 32'h0, 1'b0, 1'b1);
        add_step(1'b0, 16'hFFFC, 32'h0, 1'b0, 1'b0);
        add_step(1'b1, 16'h0214, 32'h7777_0007, 1'b1, 1'b0);
        add_step(1'b0, 16'h1234, 32'h0, 1'b0, 1'b0);
        add_step(1'b0, 16'h0218, 32'h0, 1'b1, 1'b0);
        add_step(1'b1, 16'h0A10, 32'h8888_0008, 1'b0, 1'b1);
        add_step(1'b0, 16'h0214, 32'h0, 1'b0, 1'b1);
    endtask

    // the request stays on the bus until the cache takes it
    task automatic send_request(input stim_t step);
        @(posedge clk);
        req.write <= step.write;
        req.addr  <= step.addr;
        req.wdata <= step.wdata;
        exp_hit   <= step.hit;
        exp_wb    <= step.wb;
        req_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!(req_valid && req_ready));
        req_valid <= 1'b0;
    endtask

    // memory model with random back-pressure and a refill delay of 0 to 3 cycles
    always @(posedge clk) begin
        rsp_ready     <= ($urandom % 4) != 0;
        mem_req_ready <= ($urandom % 4) != 0;
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req.write) begin
                mem_lines[mem_req.addr] <= mem_req.data;
            end else begin
                rd_addr    <= mem_req.addr;
                rd_delay   <= $urandom % 4;
                rd_pending <= 1'b1;
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            mem_rsp_valid <= 1'b0;
            rd_pending    <= 1'b0;
        end else if (rd_pending && !mem_rsp_valid) begin
            if (rd_delay != 0) begin
                rd_delay <= rd_delay - 1;
            end else begin
                mem_rsp_valid <= 1'b1;
                mem_rsp.data  <= mem_lines[rd_addr];
            end
        end
    end

    always @(posedge clk) begin
        if (rsp_valid && rsp_ready) begin
            rsp_count <= rsp_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no finish after %0d cycles, %0d of %0d responses seen",
                     cycles, rsp_count, stim_q.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        for (int la = 0; la < LINE_TOTAL; la++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_lines[la][w*WORD_WIDTH +: WORD_WIDTH] = initial_word(la * WORDS_PER_LINE + w);
            end
        end
        build_table();
        cycle_limit = RESET_CYCLES + CYCLES_PER_STEP * stim_q.size();
        repeat (RESET_CYCLES) @(posedge clk);
        n_rst <= 1'b1;
        foreach (stim_q[i]) begin
            send_request(stim_q[i]);
        end
        while (rsp_count < stim_q.size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        sva_errors = DUT.u_ctrl.u_sva.fail_count;
        $display("checker errors: %0d, assertion failures: %0d", chk_errors, sva_errors);
        if (chk_errors == 0 && sva_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cache_checker.sv
// Cache reference model and checker
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
    input  logic                        clk,
    input  logic                        n_rst,
    input  cache_bus_pkg::cpu_req_t     i_req,
    input  logic                        i_req_valid,
    input  logic                        i_req_ready,
    input  logic                        i_exp_hit,
    input  logic                        i_exp_wb,
    input  cache_bus_pkg::cpu_rsp_t     i_rsp,
    input  logic                        i_rsp_valid,
    input  logic                        i_rsp_ready,
    input  cache_bus_pkg::mem_req_t     i_mem_req,
    input  logic                        i_mem_req_valid,
    input  logic                        i_mem_req_ready,
    input  logic                        i_mem_rsp_valid,
    input  logic                        i_mem_rsp_ready,
    output int                          o_errors
);

    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam int HIT_LATENCY = 3;
    localparam int WORD_COUNT  = 1 << (ADDR_WIDTH - 2);

    word_t      ref_mem [WORD_COUNT];
    // tag held by each index, which names the victim of the next miss there
    tag_t       res_tag [LINE_COUNT];
    index_t     req_idx;
    line_addr_t exp_victim;
    cpu_req_t   cur;
    logic       busy;
    logic       exp_hit;
    logic       exp_wb;
    logic       rsp_seen;
    logic       rd_out;
    int         wait_cnt;
    int         n_rd;
    int         n_wr;

    function automatic word_t initial_word(input int unsigned waddr);
        return (word_t'(waddr) * 32'h0001_0001) ^ 32'hA5A5_0000;
    endfunction

    function automatic int unsigned word_index(input addr_t addr);
        return addr[ADDR_WIDTH-1:2];
    endfunction

    // the reference line is rebuilt from the word memory with word 0 at the bottom
    function automatic line_t line_ref(input line_addr_t la);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*WORD_WIDTH +: WORD_WIDTH] = ref_mem[{la, wsel_t'(w)}];
        end
        return l;
    endfunction

    task automatic report_mismatch(input string name, input line_t exp, input line_t act);
        $display("** Error @ %0t: %s expected %0h, got %0h", $time, name, exp, act);
        o_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error @ %0t: %s", $time, what);
        o_errors++;
    endtask

    initial begin
        o_errors = 0;
        for (int w = 0; w < WORD_COUNT; w++) begin
            ref_mem[w] = initial_word(w);
        end
    end

    task automatic check_response();
        if (!busy) begin
            report_failure("response delivered with no request in flight");
        end else begin
            if (cur.write) begin
                if (i_rsp.wack !== 1'b1) report_mismatch("o_rsp.wack", 1'b1, i_rsp.wack);
            end else begin
                if (i_rsp.rdata !== ref_mem[word_index(cur.addr)]) begin
                    report_mismatch("o_rsp.rdata", ref_mem[word_index(cur.addr)], i_rsp.rdata);
                end
                if (i_rsp.wack !== 1'b0) report_mismatch("o_rsp.wack", 1'b0, i_rsp.wack);
            end
            if (n_rd != (exp_hit ? 0 : 1)) begin
                report_failure($sformatf("%0d refill reads for access at %h", n_rd, cur.addr));
            end
            if (n_wr != (exp_wb ? 1 : 0)) begin
                report_failure($sformatf("%0d writebacks for access at %h", n_wr, cur.addr));
            end
        end
        busy = 1'b0;
    endtask

    task automatic check_mem_request();
        if (!busy) begin
            report_failure("memory request with no request in flight");
        end else if (i_mem_req.write) begin
            n_wr++;
            if (n_rd != 0) report_failure("writeback issued after the refill read");
            // the victim is the line that this index held before the access
            if (i_mem_req.addr !== exp_victim) begin
                report_mismatch("o_mem_req.addr", exp_victim, i_mem_req.addr);
            end
            if (i_mem_req.data !== line_ref(exp_victim)) begin
                report_mismatch("o_mem_req.data", line_ref(exp_victim), i_mem_req.data);
            end
        end else begin
            n_rd++;
            rd_out = 1'b1;
            if (i_mem_req.addr !== cur.addr[ADDR_WIDTH-1:OFFSET_WIDTH]) begin
                report_mismatch("o_mem_req.addr", cur.addr[ADDR_WIDTH-1:OFFSET_WIDTH],
                                i_mem_req.addr);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!n_rst) begin
            busy     = 1'b0;
            rsp_seen = 1'b0;
            rd_out   = 1'b0;
        end else begin
            // a hit on a resident line answers a fixed number of cycles after acceptance
            if (busy && !rsp_seen) begin
                if (i_rsp_valid) begin
                    rsp_seen = 1'b1;
                    if (exp_hit && wait_cnt != HIT_LATENCY) begin
                        report_mismatch("o_rsp_valid latency", HIT_LATENCY, wait_cnt);
                    end
                end else begin
                    wait_cnt++;
                end
            end
            // refill data is only taken while a refill read is outstanding
            if (i_mem_rsp_ready && !rd_out) begin
                report_failure("o_mem_rsp_ready high with no refill read outstanding");
            end
            if (i_mem_rsp_valid && i_mem_rsp_ready) rd_out = 1'b0;
            if (i_rsp_valid && i_rsp_ready) check_response();
            if (i_mem_req_valid && i_mem_req_ready) check_mem_request();
            if (i_req_valid && i_req_ready) begin
                if (busy) report_failure("request accepted before the response was taken");
                busy     = 1'b1;
                cur      = i_req;
                exp_hit  = i_exp_hit;
                exp_wb   = i_exp_wb;
                rsp_seen = 1'b0;
                wait_cnt = 0;
                n_rd     = 0;
                n_wr     = 0;
                req_idx  = i_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
                exp_victim       = {res_tag[req_idx], req_idx};
                res_tag[req_idx] = i_req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
                if (i_req.write) ref_mem[word_index(i_req.addr)] = i_req.wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/cache_sva.sv
// Cache controller handshake assertions
`timescale 1ns/1ps
`default_nettype none

module cache_sva (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        i_req_ready,
    input  cache_bus_pkg::cpu_rsp_t     i_rsp,
    input  logic                        i_rsp_valid,
    input  logic                        i_rsp_ready,
    input  cache_bus_pkg::mem_req_t     i_mem_req,
    input  logic                        i_mem_req_valid,
    input  logic                        i_mem_req_ready,
    input  logic                        i_mem_rsp_ready
);

    int fail_count = 0;

    // a stalled response keeps its valid and its contents
    rsp_held: assert property (@(posedge clk) disable iff (!n_rst)
        i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp))
        else begin
            $error("o_rsp changed or dropped while o_rsp_valid waited for i_rsp_ready");
            fail_count++;
        end

    mem_req_held: assert property (@(posedge clk) disable iff (!n_rst)
        i_mem_req_valid && !i_mem_req_ready |=> i_mem_req_valid && $stable(i_mem_req))
        else begin
            $error("o_mem_req changed or dropped while waiting for i_mem_req_ready");
            fail_count++;
        end

    // only one request is in flight, so idle and responding never overlap
    ready_excl: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_req_ready && i_rsp_valid))
        else begin
            $error("o_req_ready and o_rsp_valid high in the same cycle");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        $rose(n_rst) |-> !i_rsp_valid && !i_mem_req_valid && !i_mem_rsp_ready && i_req_ready)
        else begin
            $error("handshake outputs not idle in the first cycle after reset");
            fail_count++;
        end

endmodule

bind cache_ctrl cache_sva u_sva (
    .clk             (clk),
    .n_rst           (n_rst),
    .i_req_ready     (o_req_ready),
    .i_rsp           (o_rsp),
    .i_rsp_valid     (o_rsp_valid),
    .i_rsp_ready     (i_rsp_ready),
    .i_mem_req       (o_mem_req),
    .i_mem_req_valid (o_mem_req_valid),
    .i_mem_req_ready (i_mem_req_ready),
    .i_mem_rsp_ready (o_mem_rsp_ready)
);

`default_nettype wire

//--- src/cache_top.sv
// Data cache top level
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                        clk,
    input  logic                        n_rst,

    input  cache_bus_pkg::cpu_req_t     i_req,
    input  logic                        i_req_valid,
    output logic                        o_req_ready,
    output cache_bus_pkg::cpu_rsp_t     o_rsp,
    output logic                        o_rsp_valid,
    input  logic                        i_rsp_ready,

    output cache_bus_pkg::mem_req_t     o_mem_req,
    output logic                        o_mem_req_valid,
    input  logic                        i_mem_req_ready,
    input  cache_bus_pkg::mem_rsp_t     i_mem_rsp,
    input  logic                        i_mem_rsp_valid,
    output logic                        o_mem_rsp_ready
);

    import cache_cfg_pkg::*;

    logic       lookup;
    logic       update;
    logic       fill;
    index_t     index;
    tag_t       tag;
    wsel_t      wsel;
    word_t      wdata;
    line_t      fdata;

    logic       hit;
    logic       valid;
    logic       dirty;
    tag_t       victim_tag;
    line_t      victim_line;
    word_t      rdata;

    cache_ctrl u_ctrl (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_req           (i_req),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .o_rsp           (o_rsp),
        .o_rsp_valid     (o_rsp_valid),
        .i_rsp_ready     (i_rsp_ready),
        .o_mem_req       (o_mem_req),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .i_mem_rsp       (i_mem_rsp),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .o_mem_rsp_ready (o_mem_rsp_ready),
        .o_lookup        (lookup),
        .o_update        (update),
        .o_fill          (fill),
        .o_index         (index),
        .o_tag           (tag),
        .o_wsel          (wsel),
        .o_wdata         (wdata),
        .o_fdata         (fdata),
        .i_hit           (hit),
        .i_valid         (valid),
        .i_dirty         (dirty),
        .i_victim_tag    (victim_tag),
        .i_victim_line   (victim_line),
        .i_rdata         (rdata)
    );

    cache_array u_array (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_lookup      (lookup),
        .i_update      (update),
        .i_fill        (fill),
        .i_index       (index),
        .i_tag         (tag),
        .i_wsel        (wsel),
        .i_wdata       (wdata),
        .i_fdata       (fdata),
        .o_hit         (hit),
        .o_valid       (valid),
        .o_dirty       (dirty),
        .o_victim_tag  (victim_tag),
        .o_victim_line (victim_line),
        .o_rdata       (rdata)
    );

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
// Cache controller FSM
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                        clk,
    input  logic                        n_rst,

    input  cache_bus_pkg::cpu_req_t     i_req,
    input  logic                        i_req_valid,
    output logic                        o_req_ready,
    output cache_bus_pkg::cpu_rsp_t     o_rsp,
    output logic                        o_rsp_valid,
    input  logic                        i_rsp_ready,

    output cache_bus_pkg::mem_req_t     o_mem_req,
    output logic                        o_mem_req_valid,
    input  logic                        i_mem_req_ready,
    input  cache_bus_pkg::mem_rsp_t     i_mem_rsp,
    input  logic                        i_mem_rsp_valid,
    output logic                        o_mem_rsp_ready,

    output logic                        o_lookup,
    output logic                        o_update,
    output logic                        o_fill,
    output cache_cfg_pkg::index_t       o_index,
    output cache_cfg_pkg::tag_t         o_tag,
    output cache_cfg_pkg::wsel_t        o_wsel,
    output cache_cfg_pkg::word_t        o_wdata,
    output cache_cfg_pkg::line_t        o_fdata,
    input  logic                        i_hit,
    input  logic                        i_valid,
    input  logic                        i_dirty,
    input  cache_cfg_pkg::tag_t         i_victim_tag,
    input  cache_cfg_pkg::line_t        i_victim_line,
    input  cache_cfg_pkg::word_t        i_rdata
);

    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        FILL,
        RESPOND
    } state_t;

    state_t     state;
    state_t     state_next;
    cpu_req_t   req_q;
    word_t      rdata_q;
    line_t      fill_q;

    logic       req_fire;
    logic       rsp_fire;
    logic       mem_req_fire;
    logic       mem_rsp_fire;
    logic       miss;
    logic       victim_wb;
    logic       rsp_load;

    assign req_fire     = i_req_valid && o_req_ready;
    assign rsp_fire     = o_rsp_valid && i_rsp_ready;
    assign mem_req_fire = o_mem_req_valid && i_mem_req_ready;
    assign mem_rsp_fire = i_mem_rsp_valid && o_mem_rsp_ready;

    assign miss      = (state == COMPARE) && !i_hit;
    assign victim_wb = i_valid && i_dirty;
    // the response register loads on the first cycle of RESPOND
    assign rsp_load  = (state == RESPOND) && !o_rsp_valid;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:        if (req_fire) state_next = LOOKUP;
            LOOKUP:      state_next = COMPARE;
            COMPARE: begin
                if (i_hit) begin
                    state_next = RESPOND;
                end else if (victim_wb) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = REFILL_REQ;
                end
            end
            WRITEBACK:   if (mem_req_fire) state_next = REFILL_REQ;
            REFILL_REQ:  if (mem_req_fire) state_next = REFILL_WAIT;
            REFILL_WAIT: if (mem_rsp_fire) state_next = FILL;
            // after the fill the access runs again and completes as a hit
            FILL:        state_next = LOOKUP;
            RESPOND:     if (rsp_fire) state_next = IDLE;
            default:     state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state           <= IDLE;
            o_rsp_valid     <= 1'b0;
            o_mem_req_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (rsp_load) begin
                o_rsp_valid <= 1'b1;
            end else if (rsp_fire) begin
                o_rsp_valid <= 1'b0;
            end
            if (miss) begin
                o_mem_req_valid <= 1'b1;
            end else if ((state == REFILL_REQ) && mem_req_fire) begin
                o_mem_req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= i_req;
        end
        if ((state == COMPARE) && i_hit) begin
            rdata_q <= req_q.write ? '0 : i_rdata;
        end
        if (rsp_load) begin
            o_rsp.rdata <= rdata_q;
            o_rsp.wack  <= req_q.write;
        end
        if (mem_rsp_fire) begin
            fill_q <= i_mem_rsp.data;
        end
        // a dirty victim goes out first, the refill read follows once it is taken
        if (miss && victim_wb) begin
            o_mem_req.write <= 1'b1;
            o_mem_req.addr  <= {i_victim_tag, o_index};
            o_mem_req.data  <= i_victim_line;
        end else if (miss || ((state == WRITEBACK) && mem_req_fire)) begin
            o_mem_req.write <= 1'b0;
            o_mem_req.addr  <= {o_tag, o_index};
            o_mem_req.data  <= '0;
        end
    end

    assign o_req_ready     = (state == IDLE);
    assign o_mem_rsp_ready = (state == REFILL_WAIT);

    assign o_lookup = (state == LOOKUP);
    assign o_update = (state == COMPARE) && i_hit && req_q.write;
    assign o_fill   = (state == FILL);

    assign o_tag   = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign o_index = req_q.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign o_wsel  = req_q.addr[OFFSET_WIDTH-1 -: WSEL_WIDTH];
    assign o_wdata = req_q.wdata;
    assign o_fdata = fill_q;

endmodule

`default_nettype wire

//--- src/cache_array.sv
// Direct-mapped cache storage
`timescale 1ns/1ps
`default_nettype none

module cache_array (
    input  logic                    clk,
    input  logic                    n_rst,

    input  logic                    i_lookup,
    input  logic                    i_update,
    input  logic                    i_fill,
    input  cache_cfg_pkg::index_t   i_index,
    input  cache_cfg_pkg::tag_t     i_tag,
    input  cache_cfg_pkg::wsel_t    i_wsel,
    input  cache_cfg_pkg::word_t    i_wdata,
    input  cache_cfg_pkg::line_t    i_fdata,

    output logic                    o_hit,
    output logic                    o_valid,
    output logic                    o_dirty,
    output cache_cfg_pkg::tag_t     o_victim_tag,
    output cache_cfg_pkg::line_t    o_victim_line,
    output cache_cfg_pkg::word_t    o_rdata
);

    import cache_cfg_pkg::*;

    index_t                 idx_q;
    tag_t                   tag_q;
    logic [LINE_COUNT-1:0]  valid_q;
    logic [LINE_COUNT-1:0]  dirty_q;

    tag_t                   tag_rd;
    line_t                  line_rd;
    line_t                  line_wr;
    logic                   upd_we;
    logic                   data_we;

    // index and tag follow the RAM read so the results match the looked-up line
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            idx_q <= '0;
            tag_q <= '0;
        end else if (i_lookup) begin
            idx_q <= i_index;
            tag_q <= i_tag;
        end
    end

    assign o_valid       = valid_q[idx_q];
    assign o_dirty       = dirty_q[idx_q];
    assign o_hit         = valid_q[idx_q] && (tag_rd == tag_q);
    assign o_victim_tag  = tag_rd;
    assign o_victim_line = line_rd;

    // a word update only lands when the looked-up line really holds the address
    assign upd_we  = i_update && o_hit;
    assign data_we = upd_we || i_fill;

    assign o_rdata = line_rd[i_wsel*WORD_WIDTH +: WORD_WIDTH];

    // fill takes the whole refill line, an update replaces one word of the old line
    always_comb begin
        line_wr = line_rd;
        if (i_fill) begin
            line_wr = i_fdata;
        end else begin
            line_wr[i_wsel*WORD_WIDTH +: WORD_WIDTH] = i_wdata;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fill) begin
            valid_q[i_index] <= 1'b1;
            dirty_q[i_index] <= 1'b0;
        end else if (upd_we) begin
            dirty_q[i_index] <= 1'b1;
        end
    end

    dp_ram #(
        .DATA_WIDTH ($bits(tag_t)),
        .DEPTH      (LINE_COUNT)
    ) tag_ram (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_rd_en    (i_lookup),
        .i_rd_addr  (i_index),
        .o_rd_data  (tag_rd),
        .i_wr_en    (i_fill),
        .i_wr_addr  (i_index),
        .i_wr_data  (i_tag)
    );

    dp_ram #(
        .DATA_WIDTH ($bits(line_t)),
        .DEPTH      (LINE_COUNT)
    ) data_ram (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_rd_en    (i_lookup),
        .i_rd_addr  (i_index),
        .o_rd_data  (line_rd),
        .i_wr_en    (data_we),
        .i_wr_addr  (i_index),
        .i_wr_data  (line_wr)
    );

endmodule

`default_nettype wire

//--- src/dp_ram.sv
// Two-port RAM with registered read
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 16
) (
    input  logic                        clk,
    input  logic                        n_rst,

    input  logic                        i_rd_en,
    input  logic [$clog2(DEPTH)-1:0]    i_rd_addr,
    output logic [DATA_WIDTH-1:0]       o_rd_data,

    input  logic                        i_wr_en,
    input  logic [$clog2(DEPTH)-1:0]    i_wr_addr,
    input  logic [DATA_WIDTH-1:0]       i_wr_data
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // the read port holds its last value while no read is enabled
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- src/cache_bus_pkg.sv
// Processor and memory bus formats
`default_nettype none

package cache_bus_pkg;

    // processor request, always one aligned 32-bit word
    typedef struct packed {
        logic                   write;
        cache_cfg_pkg::addr_t   addr;
        cache_cfg_pkg::word_t   wdata;
    } cpu_req_t;

    // processor response
    // wack is set when the response closes a write
    typedef struct packed {
        cache_cfg_pkg::word_t   rdata;
        logic                   wack;
    } cpu_rsp_t;

    // memory request carrying either a victim line or a refill address
    typedef struct packed {
        logic                       write;
        cache_cfg_pkg::line_addr_t  addr;
        cache_cfg_pkg::line_t       data;
    } mem_req_t;

    // refill data returned by memory for a read request
    typedef struct packed {
        cache_cfg_pkg::line_t   data;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- src/cache_cfg_pkg.sv
// Cache geometry
`default_nettype none

package cache_cfg_pkg;

    localparam int ADDR_WIDTH     = 16;
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_BYTES     = 16;
    localparam int LINE_COUNT     = 16;

    // derived sizes, four words in each line
    localparam int WORDS_PER_LINE = LINE_BYTES / (WORD_WIDTH / 8);
    localparam int OFFSET_WIDTH   = $clog2(LINE_BYTES);
    localparam int INDEX_WIDTH    = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int WSEL_WIDTH     = $clog2(WORDS_PER_LINE);

    // byte address split as tag, index and offset from the top down
    typedef logic [ADDR_WIDTH-1:0]                addr_t;
    typedef logic [TAG_WIDTH-1:0]                 tag_t;
    typedef logic [INDEX_WIDTH-1:0]               index_t;
    typedef logic [WSEL_WIDTH-1:0]                wsel_t;

    typedef logic [WORD_WIDTH-1:0]                word_t;

    // word 0 sits in the least significant bits of a line
    typedef logic [WORDS_PER_LINE*WORD_WIDTH-1:0] line_t;

    // address of a whole line with the offset bits dropped
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0]   line_addr_t;

endpackage

`default_nettype wire
